//--- Bender.yml
package:
  name: uart

sources:
  # Package first, then the RTL bottom up
  - verilog/uart_pkg.sv
  - verilog/baud_gen.sv
  - verilog/fifo.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/uart_top.sv

  # Testbench
  - target: test
    files:
      - testbench/uart_tb.sv

//--- testbench/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	// One serial bit in clocks
	localparam int BIT_CLKS = uart_pkg::TICKS_PER_BIT * uart_pkg::CLKS_PER_TICK;
	localparam int DEPTH = 2 ** uart_pkg::FIFO_ADDR_BITS;
	// Longest wait for any single event in clocks
	localparam int WAIT_LIMIT = 20 * BIT_CLKS;
	localparam int NUM_BYTES = 20;

	logic                clk;
	logic                reset;
	logic                tx_wr;
	uart_pkg::data_t     tx_data;
	logic                tx_full;
	logic                tx_line;
	logic                rx_line;
	logic                rx_rd;
	uart_pkg::rx_entry_t rx_entry;
	logic                rx_empty;
	logic                rx_full;

	// Reference models of both FIFOs
	uart_pkg::data_t     tx_q[$];
	uart_pkg::rx_entry_t rx_q[$];

	int errors;
	int failed_tests;
	int test_errors;
	int seed_val;

	uart_top UUT (
		.clk      (clk),
		.reset    (reset),
		.tx_wr    (tx_wr),
		.tx_data  (tx_data),
		.tx_full  (tx_full),
		.tx_line  (tx_line),
		.rx_line  (rx_line),
		.rx_rd    (rx_rd),
		.rx_entry (rx_entry),
		.rx_empty (rx_empty),
		.rx_full  (rx_full)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Advance to 1 ns after the next rising edge
	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out at %0t: %s", $time, what);
		$display("tests failed");
		$finish;
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == test_errors) begin
			$display("Test %0d %s: ok", num, name);
		end else begin
			$display("Test %0d %s: FAILED with %0d errors", num, name,
				errors - test_errors);
			failed_tests++;
		end
		test_errors = errors;
	endtask

	// User write into the transmit FIFO once there is room
	task automatic write_tx(input uart_pkg::data_t b);
		int cnt;
		cnt = 0;
		while (tx_full && cnt < WAIT_LIMIT) begin
			next_cycle();
			cnt++;
		end
		if (tx_full) begin
			stop_on_timeout("the transmit FIFO never had room for a byte");
		end else begin
			tx_wr = 1'b1;
			tx_data = b;
			tx_q.push_back(b);
			next_cycle();
			tx_wr = 1'b0;
		end
	endtask

	// Serial monitor sampling each bit at its centre
	task automatic catch_tx_frame(output uart_pkg::data_t b);
		int cnt;
		int i;
		cnt = 0;
		b = '0;
		while (tx_line !== 1'b0 && cnt < WAIT_LIMIT) begin
			next_cycle();
			cnt++;
		end
		if (tx_line !== 1'b0) begin
			stop_on_timeout("no start bit ever appeared on tx_line");
		end else begin
			// Falling edge was at the last rising edge
			repeat (BIT_CLKS / 2) next_cycle();
			if (tx_line !== 1'b0) begin
				$display("Error at %0t: start bit is %b at its centre", $time, tx_line);
				errors++;
			end
			for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
				repeat (BIT_CLKS) next_cycle();
				b[i] = tx_line;
			end
			repeat (BIT_CLKS) next_cycle();
			if (tx_line !== 1'b1) begin
				$display("Error at %0t: stop bit is %b at its centre", $time, tx_line);
				errors++;
			end
		end
	endtask

	// Serial driver with an optional low stop bit
	task automatic send_frame(input uart_pkg::data_t b, input logic bad_stop);
		logic [uart_pkg::DATA_BITS+1:0] frame;
		uart_pkg::rx_entry_t e;
		int i;
		frame = {~bad_stop, b, 1'b0};
		e.data = b;
		e.frame_err = bad_stop;
		// Model drops the byte when the FIFO is full
		if (rx_q.size() < DEPTH)
			rx_q.push_back(e);
		for (i = 0; i < uart_pkg::DATA_BITS + 2; i++) begin
			rx_line = frame[i];
			repeat (BIT_CLKS) next_cycle();
		end
		rx_line = 1'b1;
	endtask

	// Compare receive FIFO head with the model
	task automatic check_head;
		uart_pkg::rx_entry_t exp;
		if (rx_q.size() == 0) begin
			$display("Error at %0t: entry %h seen with none expected", $time, rx_entry);
			errors++;
		end else begin
			exp = rx_q.pop_front();
			if (rx_entry !== exp) begin
				$display("Error at %0t: got data %h err %b, expected data %h err %b", $time,
					rx_entry.data, rx_entry.frame_err, exp.data, exp.frame_err);
				errors++;
			end
		end
	endtask

	// Wait for an entry, check it and pop it
	task automatic pop_rx;
		int cnt;
		cnt = 0;
		while (rx_empty && cnt < WAIT_LIMIT) begin
			next_cycle();
			cnt++;
		end
		if (rx_empty) begin
			stop_on_timeout("no received byte ever reached the receive FIFO");
		end else begin
			check_head();
			rx_rd = 1'b1;
			next_cycle();
			rx_rd = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		uart_pkg::data_t got_b;
		uart_pkg::data_t exp_b;
		int i;
		int k;
		int cnt;
		// Seed once for the whole run
		seed_val = 66401;
		seed_val = $urandom(seed_val);
		errors = 0;
		failed_tests = 0;
		test_errors = 0;
		reset = 1'b1;
		tx_wr = 1'b0;
		tx_data = '0;
		rx_line = 1'b1;
		rx_rd = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle outputs
		if (tx_line !== 1'b1 || rx_empty !== 1'b1 ||
			tx_full !== 1'b0 || rx_full !== 1'b0) begin
			$display("Error at %0t: reset state tx_line %b rx_empty %b tx_full %b rx_full %b",
				$time, tx_line, rx_empty, tx_full, rx_full);
			errors++;
		end
		report_test(1, "reset state");

		// Writer and monitor run side by side
		fork
			begin
				for (i = 0; i < NUM_BYTES; i++)
					write_tx(uart_pkg::data_t'($urandom));
			end
			begin
				for (k = 0; k < NUM_BYTES; k++) begin
					catch_tx_frame(got_b);
					exp_b = tx_q.pop_front();
					if (got_b !== exp_b) begin
						$display("Error at %0t: frame %0d sent %h, expected %h", $time, k,
							got_b, exp_b);
						errors++;
					end
				end
			end
		join
		report_test(2, "transmit order and framing");

		for (i = 0; i < NUM_BYTES; i++) begin
			send_frame(uart_pkg::data_t'($urandom), 1'b0);
			pop_rx();
			repeat ($urandom_range(0, 3 * BIT_CLKS)) next_cycle();
		end
		if (rx_q.size() != 0 || rx_empty !== 1'b1) begin
			$display("Error at %0t: %0d entries missing after receive", $time, rx_q.size());
			errors++;
		end
		report_test(3, "receive order");

		send_frame(uart_pkg::data_t'($urandom), 1'b1);
		pop_rx();
		// Let the receiver settle after the low stop bit
		repeat (BIT_CLKS) next_cycle();
		send_frame(uart_pkg::data_t'($urandom), 1'b0);
		pop_rx();
		report_test(4, "framing error");

		// Three more frames than fit
		for (i = 0; i < DEPTH + 3; i++)
			send_frame(uart_pkg::data_t'($urandom), 1'b0);
		if (rx_full !== 1'b1) begin
			$display("Error at %0t: rx_full is %b after overflow", $time, rx_full);
			errors++;
		end
		for (i = 0; i < DEPTH; i++)
			pop_rx();
		if (rx_empty !== 1'b1 || rx_q.size() != 0) begin
			$display("Error at %0t: rx_empty is %b after draining", $time, rx_empty);
			errors++;
		end
		report_test(5, "receive overflow");

		// Two entries ahead, then each pop lands on a push
		send_frame(uart_pkg::data_t'($urandom), 1'b0);
		send_frame(uart_pkg::data_t'($urandom), 1'b0);
		fork
			begin
				for (i = 0; i < 12; i++)
					send_frame(uart_pkg::data_t'($urandom), 1'b0);
			end
			begin
				for (k = 0; k < 12; k++) begin
					cnt = 0;
					// Align pops with receiver pushes
					while (UUT.rx_wr !== 1'b1 && cnt < WAIT_LIMIT) begin
						next_cycle();
						cnt++;
					end
					if (UUT.rx_wr !== 1'b1) begin
						stop_on_timeout("the receiver never pushed a byte");
					end else begin
						if (rx_empty !== 1'b0) begin
							$display("Error at %0t: FIFO empty at a push", $time);
							errors++;
						end
						check_head();
						rx_rd = 1'b1;
						next_cycle();
						rx_rd = 1'b0;
					end
				end
			end
		join
		pop_rx();
		pop_rx();
		if (rx_empty !== 1'b1 || rx_q.size() != 0) begin
			$display("Error at %0t: %0d entries lost in streaming", $time, rx_q.size());
			errors++;
		end
		report_test(6, "simultaneous read and write");

		$display("Summary: 6 tests run, %0d failing, %0d errors", failed_tests, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/uart_pkg.sv
verilog/baud_gen.sv
verilog/fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
testbench/uart_tb.sv

//--- verilog/baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Oversampling tick generator, 16x bit rate
module baud_gen (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// Divider count
	uart_pkg::baud_cnt_t cnt;

	// Free-running divider
	// tick is registered so it is a clean single-cycle pulse
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (cnt == uart_pkg::BAUD_LAST) begin
			// Wrap and fire
			cnt  <= '0;
			tick <= 1'b1;
		end else begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fifo.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// First-word-fall-through FIFO
////////////////////////////////////////////////////////////////////////////

module fifo #(
	parameter type payload_t = uart_pkg::data_t,
	parameter int  ADDR_BITS = uart_pkg::FIFO_ADDR_BITS
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     wr,
	input  logic     rd,
	input  payload_t w_data,
	output payload_t r_data,
	output logic     full,
	output logic     empty
);

	// Storage array
	payload_t mem [2**ADDR_BITS];

	// Pointers and their next values
	logic [ADDR_BITS-1:0] w_ptr;
	logic [ADDR_BITS-1:0] r_ptr;
	logic [ADDR_BITS-1:0] w_ptr_next;
	logic [ADDR_BITS-1:0] r_ptr_next;
	logic [ADDR_BITS-1:0] w_ptr_succ;
	logic [ADDR_BITS-1:0] r_ptr_succ;
	logic full_next;
	logic empty_next;

	// Qualified accesses
	// Write on full and read on empty drop out here
	logic do_wr;
	logic do_rd;

	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;

	// Array write, no reset on storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[w_ptr] <= w_data;
	end

	// Head is always visible
	assign r_data = mem[r_ptr];

	// Pointer and flag registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			w_ptr <= '0;
			r_ptr <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end else begin
			w_ptr <= w_ptr_next;
			r_ptr <= r_ptr_next;
			full  <= full_next;
			empty <= empty_next;
		end
	end

	// Next-state logic
	always_comb begin
		w_ptr_succ = w_ptr + 1'b1;
		r_ptr_succ = r_ptr + 1'b1;
		w_ptr_next = w_ptr;
		r_ptr_next = r_ptr;
		full_next  = full;
		empty_next = empty;
		case ({do_wr, do_rd})
			// Write only, also the empty case with both asserted
			2'b10: begin
				w_ptr_next = w_ptr_succ;
				empty_next = 1'b0;
				full_next  = (w_ptr_succ == r_ptr);
			end
			// Read only, also the full case with both asserted
			2'b01: begin
				r_ptr_next = r_ptr_succ;
				full_next  = 1'b0;
				empty_next = (r_ptr_succ == w_ptr);
			end
			// Both advance, occupancy unchanged so flags hold
			2'b11: begin
				w_ptr_next = w_ptr_succ;
				r_ptr_next = r_ptr_succ;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/uart_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// UART constants and shared types
////////////////////////////////////////////////////////////////////////////

package uart_pkg;

	// Clocks per oversampling tick, kept small for short simulations
	localparam int CLKS_PER_TICK = 4;

	// Oversampling ticks per serial bit
	localparam int TICKS_PER_BIT = 16;

	// Fixed 8N1 frame
	localparam int DATA_BITS = 8;

	// Default FIFO depth is 2**FIFO_ADDR_BITS
	localparam int FIFO_ADDR_BITS = 3;

	// Counter types for baud divider, bit timing and bit index
	typedef logic [$clog2(CLKS_PER_TICK)-1:0] baud_cnt_t;
	typedef logic [$clog2(TICKS_PER_BIT)-1:0] tick_cnt_t;
	typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;

	// Terminal counts
	localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_TICK - 1);
	localparam tick_cnt_t BIT_LAST_TICK = tick_cnt_t'(TICKS_PER_BIT - 1);
	// Half a bit, used to reach the start-bit centre
	localparam tick_cnt_t HALF_LAST_TICK = tick_cnt_t'(TICKS_PER_BIT / 2 - 1);
	localparam bit_idx_t LAST_BIT = bit_idx_t'(DATA_BITS - 1);

	// One byte of payload
	typedef logic [DATA_BITS-1:0] data_t;

	// Received byte plus stop-bit check
	typedef struct packed {
		data_t data;
		logic  frame_err;
	} rx_entry_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// UART receiver, 8N1, 16x oversampling
////////////////////////////////////////////////////////////////////////////

module uart_rx (
	input  logic                clk,
	input  logic                reset,
	input  logic                tick,
	input  logic                rx_line,
	output logic                fifo_wr,
	output uart_pkg::rx_entry_t fifo_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} state_t;

	// Two-stage synchronizer, idles high
	logic rx_meta;
	logic rx_sync;

	state_t              state;
	uart_pkg::tick_cnt_t tick_cnt;
	uart_pkg::bit_idx_t  bit_idx;
	uart_pkg::data_t     shreg;

	// Sample points
	logic bit_end;
	logic half_end;

	assign bit_end  = tick && (tick_cnt == uart_pkg::BIT_LAST_TICK);
	assign half_end = tick && (tick_cnt == uart_pkg::HALF_LAST_TICK);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
		end
	end

	// Control FSM
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= st_idle;
			tick_cnt <= '0;
			bit_idx  <= '0;
			fifo_wr  <= 1'b0;
		end else begin
			// Push is a single-cycle pulse
			fifo_wr <= 1'b0;
			case (state)
				st_idle: begin
					// Low on a tick means a possible start bit
					if (tick && !rx_sync) begin
						state    <= st_start;
						tick_cnt <= '0;
					end
				end
				st_start: begin
					if (half_end) begin
						tick_cnt <= '0;
						bit_idx  <= '0;
						// Still low at centre, otherwise a glitch
						if (!rx_sync)
							state <= st_data;
						else
							state <= st_idle;
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				st_data: begin
					if (bit_end) begin
						tick_cnt <= '0;
						if (bit_idx == uart_pkg::LAST_BIT)
							state <= st_stop;
						else
							bit_idx <= bit_idx + 1'b1;
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				st_stop: begin
					// Stop-bit centre, push whether or not the FIFO has room
					if (bit_end) begin
						fifo_wr <= 1'b1;
						state   <= st_idle;
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Payload path
	always_ff @(posedge clk) begin
		// Data bits enter at the MSB and move down, LSB ends at bit 0
		if (state == st_data && bit_end)
			shreg <= {rx_sync, shreg[uart_pkg::DATA_BITS-1:1]};
		if (state == st_stop && bit_end) begin
			fifo_data.data      <= shreg;
			fifo_data.frame_err <= ~rx_sync;
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// UART core top level
////////////////////////////////////////////////////////////////////////////

module uart_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                tx_wr,
	input  uart_pkg::data_t     tx_data,
	output logic                tx_full,
	output logic                tx_line,
	input  logic                rx_line,
	input  logic                rx_rd,
	output uart_pkg::rx_entry_t rx_entry,
	output logic                rx_empty,
	output logic                rx_full
);

	// Shared 16x tick
	logic tick;

	// Transmit FIFO to transmitter
	logic            tx_empty;
	logic            tx_rd;
	uart_pkg::data_t tx_head;

	// Receiver to receive FIFO
	logic                rx_wr;
	uart_pkg::rx_entry_t rx_push;

	baud_gen baud_gen (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	// User writes, transmitter reads
	fifo #(
		.payload_t (uart_pkg::data_t)
	) tx_fifo (
		.clk    (clk),
		.reset  (reset),
		.wr     (tx_wr),
		.rd     (tx_rd),
		.w_data (tx_data),
		.r_data (tx_head),
		.full   (tx_full),
		.empty  (tx_empty)
	);

	uart_tx uart_tx (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.fifo_empty (tx_empty),
		.fifo_data  (tx_head),
		.fifo_rd    (tx_rd),
		.tx_line    (tx_line)
	);

	uart_rx uart_rx (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.rx_line   (rx_line),
		.fifo_wr   (rx_wr),
		.fifo_data (rx_push)
	);

	// Receiver writes, user reads; pushes while full are dropped here
	fifo #(
		.payload_t (uart_pkg::rx_entry_t)
	) rx_fifo (
		.clk    (clk),
		.reset  (reset),
		.wr     (rx_wr),
		.rd     (rx_rd),
		.w_data (rx_push),
		.r_data (rx_entry),
		.full   (rx_full),
		.empty  (rx_empty)
	);

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// UART transmitter, 8N1
////////////////////////////////////////////////////////////////////////////

module uart_tx (
	input  logic            clk,
	input  logic            reset,
	input  logic            tick,
	input  logic            fifo_empty,
	input  uart_pkg::data_t fifo_data,
	output logic            fifo_rd,
	output logic            tx_line
);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} state_t;

	state_t              state;
	uart_pkg::tick_cnt_t tick_cnt;
	uart_pkg::bit_idx_t  bit_idx;
	uart_pkg::data_t     shreg;

	// End of the current bit period
	logic bit_end;

	assign bit_end = tick && (tick_cnt == uart_pkg::BIT_LAST_TICK);

	// Pop the head while idle, one cycle since state leaves idle next edge
	assign fifo_rd = (state == st_idle) && !fifo_empty;

	// Control FSM, tx_line registered to keep the line glitch free
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= st_idle;
			tick_cnt <= '0;
			bit_idx  <= '0;
			tx_line  <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					tx_line <= 1'b1;
					if (fifo_rd) begin
						state    <= st_start;
						tick_cnt <= '0;
					end
				end
				st_start: begin
					if (tick) begin
						if (tx_line) begin
							// First tick after the pop, start edge
							tx_line <= 1'b0;
						end else if (bit_end) begin
							state    <= st_data;
							tick_cnt <= '0;
							bit_idx  <= '0;
							tx_line  <= shreg[0];
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				st_data: begin
					if (bit_end) begin
						tick_cnt <= '0;
						if (bit_idx == uart_pkg::LAST_BIT) begin
							state   <= st_stop;
							tx_line <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							// Next LSB, shift happens in parallel
							tx_line <= shreg[1];
						end
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				st_stop: begin
					if (bit_end)
						state <= st_idle;
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Shift register, LSB first
	always_ff @(posedge clk) begin
		if (fifo_rd)
			shreg <= fifo_data;
		else if (state == st_data && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire
